// File: uartRxPkg.sv
package uartRxPkg;

	// Frame format is fixed at 8N1
	// Start bit low, eight data bits LSB first, one stop bit high
	// No parity bit is carried on the line

	// Data bits per frame
	localparam int dataBits = 8;

	// One received byte as it leaves the deframer
	// Same type travels through the FIFO to the consumer
	typedef logic [dataBits-1:0] rxByte_t;

	// Deframer states
	// idle      line high, waiting for a falling edge
	// start     counting half a bit to the middle of the start bit
	// data      sampling the data bits one full bit apart
	// stop      counting to the middle of the stop bit
	// waitIdle  bad stop bit seen, waiting for the line to go high again
	typedef enum logic [2:0] {
		idle     = 3'd0,
		start    = 3'd1,
		data     = 3'd2,
		stop     = 3'd3,
		waitIdle = 3'd4
	} rxState_t;

	// Encodings 5 to 7 are unused
	// The deframer falls back to idle if it ever lands there

	// Notes on timing
	// The line filter adds four cycles of latency to rxd
	// The start sample lands half a bit after the filtered falling edge
	// Each further sample is one full bit later
	// The stop sample is nine bits after the start sample

endpackage

// File: rxLineFilter.sv
module rxLineFilter (
	input  logic clk,
	input  logic arstN,
	input  logic rxd,
	output logic lineLevel,
	output logic lineFall
);

	// Two-flop synchronizer on the raw serial input
	logic syncMeta;
	logic syncOut;

	// Two older synchronized samples for the vote
	logic [1:0] history;

	// Majority of the newest three samples
	logic vote;

	// Any two of three decide the level
	// A single low sample is outvoted
	assign vote = (syncOut & history[0]) | (syncOut & history[1]) | (history[0] & history[1]);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			// Idle line is high, so everything starts high
			syncMeta  <= 1'b1;
			syncOut   <= 1'b1;
			history   <= 2'b11;
			lineLevel <= 1'b1;
			lineFall  <= 1'b0;
		end else begin
			syncMeta <= rxd;
			syncOut  <= syncMeta;
			// Shift the synchronized bit into the history
			history  <= {history[0], syncOut};
			// Registered vote gives the fourth cycle of latency
			lineLevel <= vote;
			// High for the first cycle that lineLevel reads low
			lineFall  <= lineLevel & ~vote;
		end
	end

endmodule

// File: rxDeframer.sv
module rxDeframer #(
	parameter int clkPerBit = 1831
) (
	input  logic               clk,
	input  logic               arstN,
	input  logic               lineLevel,
	input  logic               lineFall,
	output uartRxPkg::rxByte_t byteData,
	output logic               bytePush,
	output logic               frameErr
);

	// Counter wide enough for a full bit time
	localparam int cntW = $clog2(clkPerBit);
	// Index wide enough to count the data bits
	localparam int idxW = $clog2(uartRxPkg::dataBits);

	// Reload values, the counter expires on zero
	localparam logic [cntW-1:0] halfBit = cntW'(clkPerBit / 2 - 1);
	localparam logic [cntW-1:0] fullBit = cntW'(clkPerBit - 1);
	localparam logic [idxW-1:0] lastBit = idxW'(uartRxPkg::dataBits - 1);

	uartRxPkg::rxState_t state;

	// Bit-timing counter and data bit index
	logic [cntW-1:0] bitCnt;
	logic [idxW-1:0] bitIdx;

	// Middle of the current bit reached
	logic sampleNow;

	// Data shift register
	uartRxPkg::rxByte_t shiftReg;

	assign sampleNow = (bitCnt == '0);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state    <= uartRxPkg::idle;
			bitCnt   <= '0;
			bitIdx   <= '0;
			bytePush <= 1'b0;
			frameErr <= 1'b0;
		end else begin
			// Strobes are single cycle by default
			bytePush <= 1'b0;
			frameErr <= 1'b0;
			case (state)
				uartRxPkg::idle: begin
					// Falling edge may be a start bit
					if (lineFall) begin
						bitCnt <= halfBit;
						state  <= uartRxPkg::start;
					end
				end
				uartRxPkg::start: begin
					if (sampleNow) begin
						// Start bit still low in its middle
						if (!lineLevel) begin
							bitCnt <= fullBit;
							bitIdx <= '0;
							state  <= uartRxPkg::data;
						end else begin
							// False start, the low was too short
							state <= uartRxPkg::idle;
						end
					end else begin
						bitCnt <= bitCnt - 1'b1;
					end
				end
				uartRxPkg::data: begin
					if (sampleNow) begin
						bitCnt <= fullBit;
						if (bitIdx == lastBit) begin
							state <= uartRxPkg::stop;
						end else begin
							bitIdx <= bitIdx + 1'b1;
						end
					end else begin
						bitCnt <= bitCnt - 1'b1;
					end
				end
				uartRxPkg::stop: begin
					if (sampleNow) begin
						if (lineLevel) begin
							// Good frame, hand the byte to the FIFO
							bytePush <= 1'b1;
							state    <= uartRxPkg::idle;
						end else begin
							// Stop bit low, drop the byte
							frameErr <= 1'b1;
							state    <= uartRxPkg::waitIdle;
						end
					end else begin
						bitCnt <= bitCnt - 1'b1;
					end
				end
				uartRxPkg::waitIdle: begin
					// Line may be held low (break), wait for it to release
					if (lineLevel) begin
						state <= uartRxPkg::idle;
					end
				end
				default: begin
					state <= uartRxPkg::idle;
				end
			endcase
		end
	end

	// Data bits arrive LSB first, so shift in from the top
	always_ff @(posedge clk) begin
		if (state == uartRxPkg::data && sampleNow) begin
			shiftReg <= {lineLevel, shiftReg[uartRxPkg::dataBits-1:1]};
		end
	end

	// Stable from the last data sample until the next frame
	assign byteData = shiftReg;

endmodule

// File: rxByteFifo.sv
module rxByteFifo #(
	parameter int fifoDepth = 4
) (
	input  logic               clk,
	input  logic               arstN,
	input  uartRxPkg::rxByte_t byteData,
	input  logic               bytePush,
	output uartRxPkg::rxByte_t rxData,
	output logic               rxValid,
	input  logic               rxReady,
	output logic               overrun
);

	// Depth is a power of two, pointers wrap by themselves
	localparam int ptrW = $clog2(fifoDepth);
	localparam logic [ptrW:0] fullCount = (ptrW + 1)'(fifoDepth);

	uartRxPkg::rxByte_t mem [fifoDepth];

	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	// One bit wider than the pointers to tell full from empty
	logic [ptrW:0]   count;

	logic full;
	logic pop;
	logic pushOk;

	assign full = (count == fullCount);
	// Consumer takes the head entry
	assign pop = rxValid & rxReady;
	// A pop in the same cycle frees the slot for the push
	assign pushOk = bytePush & (~full | pop);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrPtr   <= '0;
			rdPtr   <= '0;
			count   <= '0;
			overrun <= 1'b0;
		end else begin
			if (pushOk) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			// Count only moves when exactly one side acts
			if (pushOk && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !pushOk) begin
				count <= count - 1'b1;
			end
			// Lost byte, one-cycle pulse
			overrun <= bytePush & ~pushOk;
		end
	end

	// Storage write
	always_ff @(posedge clk) begin
		if (pushOk) begin
			mem[wrPtr] <= byteData;
		end
	end

	// Head entry is always on the output
	assign rxData  = mem[rdPtr];
	assign rxValid = (count != '0);

endmodule

// File: uartRxTop.sv
module uartRxTop #(
	parameter int clkPerBit = 1831,
	parameter int fifoDepth = 4
) (
	input  logic               clk,
	input  logic               arstN,
	input  logic               rxd,
	output uartRxPkg::rxByte_t rxData,
	output logic               rxValid,
	input  logic               rxReady,
	output logic               frameErr,
	output logic               overrun
);

	// Filtered line and its falling-edge strobe
	logic lineLevel;
	logic lineFall;

	// Deframed byte towards the FIFO
	uartRxPkg::rxByte_t byteData;
	logic               bytePush;

	rxLineFilter u_lineFilter (
		.clk       (clk),
		.arstN     (arstN),
		.rxd       (rxd),
		.lineLevel (lineLevel),
		.lineFall  (lineFall)
	);

	rxDeframer #(
		.clkPerBit (clkPerBit)
	) u_deframer (
		.clk       (clk),
		.arstN     (arstN),
		.lineLevel (lineLevel),
		.lineFall  (lineFall),
		.byteData  (byteData),
		.bytePush  (bytePush),
		.frameErr  (frameErr)
	);

	rxByteFifo #(
		.fifoDepth (fifoDepth)
	) u_byteFifo (
		.clk      (clk),
		.arstN    (arstN),
		.byteData (byteData),
		.bytePush (bytePush),
		.rxData   (rxData),
		.rxValid  (rxValid),
		.rxReady  (rxReady),
		.overrun  (overrun)
	);

endmodule

// File: uartRxTb_properties.sv
module uartRxTbProperties (
	input logic               clk,
	input logic               arstN,
	input uartRxPkg::rxByte_t rxData,
	input logic               rxValid,
	input logic               rxReady,
	input logic               frameErr,
	input logic               overrun
);

	timeunit 1ns;
	timeprecision 100ps;

	// Stalled output holds its byte until the consumer takes it
	property holdWhileStalled;
		@(posedge clk) disable iff (!arstN)
			(rxValid && !rxReady) |=> (rxValid && $stable(rxData));
	endproperty

	// Error strobes are single cycle
	property frameErrPulse;
		@(posedge clk) disable iff (!arstN) frameErr |=> !frameErr;
	endproperty

	property overrunPulse;
		@(posedge clk) disable iff (!arstN) overrun |=> !overrun;
	endproperty

	// Outputs stay quiet in reset
	property quietInReset;
		@(posedge clk) !arstN |-> (!rxValid && !frameErr && !overrun);
	endproperty

	assert property (holdWhileStalled) else $error("rxValid or rxData moved while stalled");
	assert property (frameErrPulse) else $error("frameErr longer than one cycle");
	assert property (overrunPulse) else $error("overrun longer than one cycle");
	assert property (quietInReset) else $error("output active during reset");

endmodule

// File: uartRxTb.sv
module uartRxTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int clkPerBit = 16;
	localparam int fifoDepth = 4;
	localparam int numRows = 18;
	// Longest any single wait may take
	localparam int timeoutCycles = 12 * clkPerBit;

	typedef enum logic [1:0] {
		kindNormal,
		kindGlitch,
		kindFalseStart
	} rowKind_t;

	logic               clk = 1'b0;
	logic               arstN;
	logic               rxd;
	uartRxPkg::rxByte_t rxData;
	logic               rxValid;
	logic               rxReady;
	logic               frameErr;
	logic               overrun;

	// Stimulus table
	string              rowName [numRows];
	uartRxPkg::rxByte_t rowData [numRows];
	logic               rowStop [numRows];
	logic               rowHold [numRows];
	rowKind_t           rowKind [numRows];
	int                 rowCount = 0;

	// What the consumer side has seen so far
	uartRxPkg::rxByte_t gotBytes[$];
	int                 frameErrCount = 0;
	int                 overrunCount = 0;

	// Stall group bookkeeping
	uartRxPkg::rxByte_t stallExpect[$];
	int                 stallStart;
	int                 stallOverrunStart;

	always #50 clk = ~clk;

	uartRxTop #(
		.clkPerBit (clkPerBit),
		.fifoDepth (fifoDepth)
	) u_dut (
		.clk      (clk),
		.arstN    (arstN),
		.rxd      (rxd),
		.rxData   (rxData),
		.rxValid  (rxValid),
		.rxReady  (rxReady),
		.frameErr (frameErr),
		.overrun  (overrun)
	);

	bind uartRxTop uartRxTbProperties u_props (
		.clk      (clk),
		.arstN    (arstN),
		.rxData   (rxData),
		.rxValid  (rxValid),
		.rxReady  (rxReady),
		.frameErr (frameErr),
		.overrun  (overrun)
	);

	// Sampled mid-cycle so a transfer seen here happens on the next rising edge
	always @(negedge clk) begin
		if (arstN) begin
			if (rxValid && rxReady) begin
				gotBytes.push_back(rxData);
			end
			if (frameErr) begin
				frameErrCount++;
			end
			if (overrun) begin
				overrunCount++;
			end
		end
	end

	task automatic stopRun();
		$display("tests failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic checkByte(input string name, input uartRxPkg::rxByte_t expected,
		input uartRxPkg::rxByte_t actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
			stopRun();
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected %b, actual %b", name, expected, actual);
			stopRun();
		end
	endtask

	task automatic checkCount(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
			stopRun();
		end
	endtask

	task automatic reportTimeout(input string name, input string what);
		$display("Timeout in %s: %s never came", name, what);
		stopRun();
	endtask

	task automatic addRow(input string name, input uartRxPkg::rxByte_t data, input logic stopLevel,
		input logic hold, input rowKind_t kind);
		rowName[rowCount] = name;
		rowData[rowCount] = data;
		rowStop[rowCount] = stopLevel;
		rowHold[rowCount] = hold;
		rowKind[rowCount] = kind;
		rowCount++;
	endtask

	task automatic fillTable();
		addRow("byte00", 8'h00, 1'b1, 1'b0, kindNormal);
		addRow("byte01", 8'h01, 1'b1, 1'b0, kindNormal);
		// Reference pattern sent LSB first
		addRow("byte77", 8'h77, 1'b1, 1'b0, kindNormal);
		addRow("byteFF", 8'hFF, 1'b1, 1'b0, kindNormal);
		addRow("byteA5", 8'hA5, 1'b1, 1'b0, kindNormal);
		addRow("badStop", 8'h3C, 1'b0, 1'b0, kindNormal);
		addRow("afterBadStop", 8'hC3, 1'b1, 1'b0, kindNormal);
		addRow("glitch", 8'h00, 1'b1, 1'b0, kindGlitch);
		addRow("falseStart", 8'h00, 1'b1, 1'b0, kindFalseStart);
		for (int k = 0; k < 4; k++) begin
			addRow($sformatf("random%0d", k), uartRxPkg::rxByte_t'($urandom()), 1'b1, 1'b0,
				kindNormal);
		end
		// fifoDepth + 1 frames with the consumer stalled
		for (int k = 0; k <= fifoDepth; k++) begin
			addRow($sformatf("stall%0d", k), uartRxPkg::rxByte_t'(8'h11 * (k + 1)), 1'b1, 1'b1,
				kindNormal);
		end
	endtask

	// Called right after a rising edge
	task automatic driveBit(input logic level);
		rxd <= level;
		repeat (clkPerBit) @(posedge clk);
	endtask

	task automatic idleBits(input int bits);
		repeat (bits) driveBit(1'b1);
	endtask

	// Start bit, data LSB first, then the stop level
	task automatic sendFrame(input uartRxPkg::rxByte_t data, input logic stopLevel);
		driveBit(1'b0);
		for (int i = 0; i < uartRxPkg::dataBits; i++) begin
			driveBit(data[i]);
		end
		driveBit(stopLevel);
	endtask

	task automatic waitByteCount(input string name, input int target);
		int n;
		n = 0;
		while (gotBytes.size() < target && n < timeoutCycles) begin
			@(posedge clk);
			n++;
		end
		if (gotBytes.size() < target) begin
			reportTimeout(name, "rxValid transfer");
		end
	endtask

	task automatic waitFrameErr(input string name, input int target);
		int n;
		n = 0;
		while (frameErrCount < target && n < timeoutCycles) begin
			@(posedge clk);
			n++;
		end
		if (frameErrCount < target) begin
			reportTimeout(name, "frameErr pulse");
		end
	endtask

	task automatic waitOverrun(input string name, input int target);
		int n;
		n = 0;
		while (overrunCount < target && n < timeoutCycles) begin
			@(posedge clk);
			n++;
		end
		if (overrunCount < target) begin
			reportTimeout(name, "overrun pulse");
		end
	endtask

	task automatic waitValidLow(input string name);
		int n;
		n = 0;
		while (rxValid && n < timeoutCycles) begin
			@(posedge clk);
			n++;
		end
		if (rxValid) begin
			reportTimeout(name, "rxValid falling");
		end
	endtask

	task automatic checkResetFlags(input string name);
		checkFlag({name, " rxValid"}, 1'b0, rxValid);
		checkFlag({name, " frameErr"}, 1'b0, frameErr);
		checkFlag({name, " overrun"}, 1'b0, overrun);
	endtask

	task automatic runGoodFrame(input int row);
		int start;
		int errStart;
		start = gotBytes.size();
		errStart = frameErrCount;
		sendFrame(rowData[row], 1'b1);
		waitByteCount(rowName[row], start + 1);
		idleBits(1);
		checkCount({rowName[row], " transfers"}, start + 1, gotBytes.size());
		checkByte({rowName[row], " rxData"}, rowData[row], gotBytes[start]);
		checkCount({rowName[row], " frameErr pulses"}, errStart, frameErrCount);
	endtask

	task automatic runBadStop(input int row);
		int start;
		int errStart;
		start = gotBytes.size();
		errStart = frameErrCount;
		sendFrame(rowData[row], 1'b0);
		idleBits(1);
		waitFrameErr(rowName[row], errStart + 1);
		checkCount({rowName[row], " frameErr pulses"}, errStart + 1, frameErrCount);
		checkCount({rowName[row], " transfers"}, start, gotBytes.size());
		checkFlag({rowName[row], " rxValid"}, 1'b0, rxValid);
	endtask

	// Short low on an idle line and then twelve quiet bit times
	task automatic runNoise(input int row, input int lowCycles);
		int start;
		int errStart;
		start = gotBytes.size();
		errStart = frameErrCount;
		rxd <= 1'b0;
		repeat (lowCycles) @(posedge clk);
		rxd <= 1'b1;
		repeat (timeoutCycles) @(posedge clk);
		checkCount({rowName[row], " transfers"}, start, gotBytes.size());
		checkCount({rowName[row], " frameErr pulses"}, errStart, frameErrCount);
	endtask

	task automatic drainStall(input int row);
		int k;
		waitOverrun(rowName[row], stallOverrunStart + 1);
		idleBits(1);
		checkCount({rowName[row], " overrun pulses"}, stallOverrunStart + 1, overrunCount);
		// Head of the full FIFO is the oldest stalled byte
		checkFlag({rowName[row], " rxValid"}, 1'b1, rxValid);
		checkByte({rowName[row], " head while stalled"}, stallExpect[0], rxData);
		rxReady <= 1'b1;
		waitByteCount(rowName[row], stallStart + stallExpect.size());
		for (k = 0; k < stallExpect.size(); k++) begin
			checkByte($sformatf("%s drained byte %0d", rowName[row], k), stallExpect[k],
				gotBytes[stallStart + k]);
		end
		waitValidLow(rowName[row]);
		checkCount({rowName[row], " drained transfers"}, stallStart + stallExpect.size(),
			gotBytes.size());
	endtask

	task automatic runStalledFrame(input int row);
		// First row of a group stalls the consumer
		if (row == 0 || !rowHold[row-1]) begin
			rxReady <= 1'b0;
			stallStart = gotBytes.size();
			stallOverrunStart = overrunCount;
			stallExpect.delete();
		end
		// Only the first fifoDepth bytes fit
		if (stallExpect.size() < fifoDepth) begin
			stallExpect.push_back(rowData[row]);
		end
		sendFrame(rowData[row], rowStop[row]);
		idleBits(1);
		if (row == numRows - 1 || !rowHold[row+1]) begin
			drainStall(row);
		end
	endtask

	initial begin
		int row;
		arstN = 1'b0;
		rxd = 1'b1;
		rxReady = 1'b1;
		void'($urandom(32'ha6de));
		fillTable();

		// Two rising edges in reset
		@(posedge clk);
		@(negedge clk);
		checkResetFlags("during reset");
		@(posedge clk);
		arstN <= 1'b1;
		@(negedge clk);
		checkResetFlags("after reset");
		@(posedge clk);
		idleBits(2);

		for (row = 0; row < numRows; row++) begin
			if (rowHold[row]) begin
				runStalledFrame(row);
			end else if (rowKind[row] == kindGlitch) begin
				runNoise(row, 1);
			end else if (rowKind[row] == kindFalseStart) begin
				// Below a quarter of a bit
				runNoise(row, clkPerBit / 4 - 1);
			end else if (rowStop[row]) begin
				runGoodFrame(row);
			end else begin
				runBadStop(row);
			end
		end

		$display("all tests passed");
		$finish;
	end

endmodule

// File: files.f
uartRxPkg.sv
rxLineFilter.sv
rxDeframer.sv
rxByteFifo.sv
uartRxTop.sv
uartRxTb_properties.sv
uartRxTb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = uartRxTb
FILELIST = files.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "tests failed" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
